// File: pm_config.svh
// Program memory configuration
`ifndef PM_CONFIG_SVH
`define PM_CONFIG_SVH

// Memory geometry
`define PM_ADR_W        8       // Word address bits, 256 words
`define PM_DAT_W        32      // Instruction word bits
`define PM_STRB_W       4       // One strobe per byte lane

// Fetch unit
`define PM_FIFO_DEPTH   4       // Output queue entries

`endif

// File: pm_pkg.sv
// Program memory types
`include "pm_config.svh"

package pm_pkg;

    // Word address into the program memory
    typedef logic [`PM_ADR_W-1:0]   pm_adr_t;       // Wraps at end of memory

    // Data or instruction word
    typedef logic [`PM_DAT_W-1:0]   pm_dat_t;       // Full word

    // Byte write enables, bit i covers byte lane i
    typedef logic [`PM_STRB_W-1:0]  pm_strb_t;      // Lane enables

endpackage

// File: pm_sdp_ram.sv
// Program memory array
`timescale 1ns/1ps
`include "pm_config.svh"

module pm_sdp_ram
(
    input  wire                 CLK_IN,         // Clock

    // Port A, write only
    input  wire                 wr_en_i,        // Write enable
    input  pm_pkg::pm_strb_t    wr_be_i,        // Byte enables
    input  pm_pkg::pm_adr_t     wr_adr_i,       // Write address
    input  pm_pkg::pm_dat_t     wr_dat_i,       // Write data

    // Port B, read only
    input  wire                 rd_en_i,        // Read enable
    input  pm_pkg::pm_adr_t     rd_adr_i,       // Read address
    output pm_pkg::pm_dat_t     rd_dat_o        // Read data, one cycle later
);

    import pm_pkg::*;

    localparam int DEPTH  = 2 ** `PM_ADR_W;             // Words in array
    localparam int BYTE_W = `PM_DAT_W / `PM_STRB_W;     // Bits per lane

    // Storage, no reset like block RAM
    pm_dat_t mem [DEPTH];

    // Port A byte-wise write
    always_ff @(posedge CLK_IN)
    begin
        if (wr_en_i)
        begin
            for (int i = 0; i < `PM_STRB_W; i++)
            begin
                if (wr_be_i[i])                     // Only strobed lanes
                    mem[wr_adr_i][i*BYTE_W +: BYTE_W] <= wr_dat_i[i*BYTE_W +: BYTE_W];
            end
        end
    end

    // Port B registered read
    // Nonblocking update of mem gives read-first on an address collision
    always_ff @(posedge CLK_IN)
    begin
        if (rd_en_i)
            rd_dat_o <= mem[rd_adr_i];              // Old word on collision
    end

endmodule

// File: pm_dp_ram.sv
// Program memory wrapper
`timescale 1ns/1ps
`include "pm_config.svh"

module pm_dp_ram
(
    input  wire                 CLK_IN,         // Clock
    input  wire                 rst_i,          // Synchronous reset

    // Init stream from host
    input  wire                 init_str_i,     // Clear load pointer
    input  wire                 init_vld_i,     // Word valid
    input  pm_pkg::pm_dat_t     init_dat_i,     // Word

    // Patch write port
    input  wire                 wr_vld_i,       // Valid
    output logic                wr_rdy_o,       // Ready
    input  pm_pkg::pm_adr_t     wr_adr_i,       // Address
    input  pm_pkg::pm_dat_t     wr_dat_i,       // Data
    input  pm_pkg::pm_strb_t    wr_strb_i,      // Byte strobes

    // Read port to fetch unit
    input  wire                 rd_en_i,        // Read enable
    input  pm_pkg::pm_adr_t     rd_adr_i,       // Read address
    output pm_pkg::pm_dat_t     rd_dat_o        // Read data
);

    import pm_pkg::*;

    pm_adr_t    init_wp;        // Load pointer
    logic       wr_acc;         // Patch transfer this cycle
    logic       a_en;           // Port A enable
    pm_strb_t   a_be;           // Port A byte enables
    pm_adr_t    a_adr;          // Port A address
    pm_dat_t    a_dat;          // Port A data

    // Load pointer, a clear wins over an increment
    always_ff @(posedge CLK_IN)
    begin
        if (rst_i || init_str_i)
            init_wp <= '0;
        else if (init_vld_i)
            init_wp <= init_wp + pm_adr_t'(1);      // Wraps at end of memory
    end

    // Patch port stalls while init words stream
    assign wr_rdy_o = ~init_vld_i;
    assign wr_acc   = wr_vld_i & wr_rdy_o;

    // Port A mux, init has priority
    assign a_en  = init_vld_i | wr_acc;
    assign a_be  = init_vld_i ? {`PM_STRB_W{1'b1}} : wr_strb_i;    // Full word on init
    assign a_adr = init_vld_i ? init_wp : wr_adr_i;
    assign a_dat = init_vld_i ? init_dat_i : wr_dat_i;

    // Memory array
    pm_sdp_ram u_mem
    (
        .CLK_IN     (CLK_IN),
        .wr_en_i    (a_en),
        .wr_be_i    (a_be),
        .wr_adr_i   (a_adr),
        .wr_dat_i   (a_dat),
        .rd_en_i    (rd_en_i),
        .rd_adr_i   (rd_adr_i),
        .rd_dat_o   (rd_dat_o)
    );

endmodule

// File: pm_fetch.sv
// Sequential instruction fetch
`timescale 1ns/1ps
`include "pm_config.svh"

module pm_fetch
(
    input  wire                 CLK_IN,         // Clock
    input  wire                 rst_i,          // Synchronous reset

    // Control
    input  wire                 start_i,        // Start or redirect
    input  pm_pkg::pm_adr_t     start_adr_i,    // First address to fetch

    // Memory read port
    output logic                rd_en_o,        // Read issue
    output pm_pkg::pm_adr_t     rd_adr_o,       // Read address
    input  pm_pkg::pm_dat_t     rd_dat_i,       // Read data, one cycle after issue

    // Instruction stream
    output logic                ins_vld_o,      // Valid
    input  wire                 ins_rdy_i,      // Ready
    output pm_pkg::pm_adr_t     ins_adr_o,      // Instruction address
    output pm_pkg::pm_dat_t     ins_dat_o       // Instruction word
);

    import pm_pkg::*;

    localparam int DEPTH = `PM_FIFO_DEPTH;                      // Queue entries
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;     // Queue pointer bits
    localparam int CNT_W = $clog2(DEPTH + 1);                   // Occupancy bits

    logic               run;            // Fetch active
    pm_adr_t            nxt_adr;        // Next read address
    logic               inf_vld;        // Read in flight
    pm_adr_t            inf_adr;        // Address tag of that read

    pm_adr_t            q_adr [DEPTH];  // Queued addresses
    pm_dat_t            q_dat [DEPTH];  // Queued words
    logic [PTR_W-1:0]   q_wp;           // Write pointer
    logic [PTR_W-1:0]   q_rp;           // Read pointer
    logic [CNT_W-1:0]   q_cnt;          // Occupancy
    logic [CNT_W:0]     q_used;         // Occupancy plus reads in flight
    logic               q_push;
    logic               q_pop;

    // Queue pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // Reserve a slot for every read before it issues
    assign q_used  = {1'b0, q_cnt} + {{CNT_W{1'b0}}, inf_vld};
    assign rd_en_o = run & ~start_i & (q_used < DEPTH[CNT_W:0]);
    assign rd_adr_o = nxt_adr;

    // Returning read enters queue, accepted word leaves it
    assign q_push = inf_vld;
    assign q_pop  = ins_vld_o & ins_rdy_i;

    // Head of queue drives the stream
    assign ins_vld_o = (q_cnt != '0);
    assign ins_adr_o = q_adr[q_rp];
    assign ins_dat_o = q_dat[q_rp];

    // Control state
    always_ff @(posedge CLK_IN)
    begin
        if (rst_i)
        begin
            run     <= 1'b0;                // Idle until first start
            nxt_adr <= '0;
            inf_vld <= 1'b0;
            q_wp    <= '0;
            q_rp    <= '0;
            q_cnt   <= '0;
        end
        else if (start_i)
        begin
            run     <= 1'b1;
            nxt_adr <= start_adr_i;         // Restart point
            inf_vld <= 1'b0;                // Drop returning read
            q_wp    <= '0;                  // Flush queue
            q_rp    <= '0;
            q_cnt   <= '0;
        end
        else
        begin
            inf_vld <= rd_en_o;

            if (rd_en_o)
                nxt_adr <= nxt_adr + pm_adr_t'(1);  // Wraps at end of memory

            if (q_push)
                q_wp <= ptr_inc(q_wp);

            if (q_pop)
                q_rp <= ptr_inc(q_rp);

            case ({q_push, q_pop})
                2'b10   : q_cnt <= q_cnt + CNT_W'(1);
                2'b01   : q_cnt <= q_cnt - CNT_W'(1);
                default : q_cnt <= q_cnt;           // Both or neither
            endcase
        end
    end

    // Address tag follows the read through the RAM latency
    always_ff @(posedge CLK_IN)
    begin
        if (rd_en_o)
            inf_adr <= nxt_adr;
    end

    // Queue storage
    always_ff @(posedge CLK_IN)
    begin
        if (q_push)
        begin
            q_adr[q_wp] <= inf_adr;
            q_dat[q_wp] <= rd_dat_i;
        end
    end

endmodule

// File: pm_top.sv
// Program memory with fetch
`timescale 1ns/1ps
`include "pm_config.svh"

module pm_top
(
    input  wire                 CLK_IN,         // Clock
    input  wire                 rst_i,          // Synchronous reset

    // Init stream
    input  wire                 init_str_i,     // Clear load pointer
    input  wire                 init_vld_i,     // Word valid
    input  pm_pkg::pm_dat_t     init_dat_i,     // Word

    // Patch write port
    input  wire                 wr_vld_i,       // Valid
    output logic                wr_rdy_o,       // Ready
    input  pm_pkg::pm_adr_t     wr_adr_i,       // Address
    input  pm_pkg::pm_dat_t     wr_dat_i,       // Data
    input  pm_pkg::pm_strb_t    wr_strb_i,      // Byte strobes

    // Fetch control
    input  wire                 start_i,        // Start or redirect
    input  pm_pkg::pm_adr_t     start_adr_i,    // Start address

    // Instruction stream
    output logic                ins_vld_o,      // Valid
    input  wire                 ins_rdy_i,      // Ready
    output pm_pkg::pm_adr_t     ins_adr_o,      // Instruction address
    output pm_pkg::pm_dat_t     ins_dat_o       // Instruction word
);

    import pm_pkg::*;

    // Internal read port
    logic       rd_en;          // Read issue
    pm_adr_t    rd_adr;         // Read address
    pm_dat_t    rd_dat;         // Read data

    // Memory with load pointer and port A mux
    pm_dp_ram u_ram
    (
        .CLK_IN         (CLK_IN),
        .rst_i          (rst_i),
        .init_str_i     (init_str_i),
        .init_vld_i     (init_vld_i),
        .init_dat_i     (init_dat_i),
        .wr_vld_i       (wr_vld_i),
        .wr_rdy_o       (wr_rdy_o),
        .wr_adr_i       (wr_adr_i),
        .wr_dat_i       (wr_dat_i),
        .wr_strb_i      (wr_strb_i),
        .rd_en_i        (rd_en),
        .rd_adr_i       (rd_adr),
        .rd_dat_o       (rd_dat)
    );

    // Fetch unit
    pm_fetch u_fetch
    (
        .CLK_IN         (CLK_IN),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .start_adr_i    (start_adr_i),
        .rd_en_o        (rd_en),
        .rd_adr_o       (rd_adr),
        .rd_dat_i       (rd_dat),
        .ins_vld_o      (ins_vld_o),
        .ins_rdy_i      (ins_rdy_i),
        .ins_adr_o      (ins_adr_o),
        .ins_dat_o      (ins_dat_o)
    );

endmodule

// File: tb_pm_top.sv
// Program memory testbench
`timescale 1ns/1ps
`include "pm_config.svh"

module tb_pm_top;

    import pm_pkg::*;

    localparam int          MEM_WORDS = 2 ** `PM_ADR_W;    // Words in program memory
    localparam int          HS_LIMIT  = 64;                 // Cycles allowed for patch accept
    localparam int          VLD_LIMIT = 16;                 // Cycles from start to first valid
    localparam logic [15:0] LFSR_SEED = 16'd47292;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;           // x^16 + x^14 + x^13 + x^11 + 1

    // DUT inputs
    logic       CLK_IN;
    logic       rst_i;
    logic       init_str_i;
    logic       init_vld_i;
    pm_dat_t    init_dat_i;
    logic       wr_vld_i;
    pm_adr_t    wr_adr_i;
    pm_dat_t    wr_dat_i;
    pm_strb_t   wr_strb_i;
    logic       start_i;
    pm_adr_t    start_adr_i;
    logic       ins_rdy_i;

    // DUT outputs
    logic       wr_rdy_o;
    logic       ins_vld_o;
    pm_adr_t    ins_adr_o;
    pm_dat_t    ins_dat_o;

    // Model of the memory contents
    pm_dat_t        shadow [MEM_WORDS];     // Expected word per address
    pm_adr_t        load_ptr;               // Expected load pointer
    logic [15:0]    lfsr_state;             // Random source

    // Stream checker state
    logic           started = 1'b0;         // Seen a start since reset
    pm_adr_t        base_adr;               // Address of last start
    int             acc_cnt = 0;            // Words accepted since last start

    pm_top u_dut
    (
        .CLK_IN         (CLK_IN),
        .rst_i          (rst_i),
        .init_str_i     (init_str_i),
        .init_vld_i     (init_vld_i),
        .init_dat_i     (init_dat_i),
        .wr_vld_i       (wr_vld_i),
        .wr_rdy_o       (wr_rdy_o),
        .wr_adr_i       (wr_adr_i),
        .wr_dat_i       (wr_dat_i),
        .wr_strb_i      (wr_strb_i),
        .start_i        (start_i),
        .start_adr_i    (start_adr_i),
        .ins_vld_o      (ins_vld_o),
        .ins_rdy_i      (ins_rdy_i),
        .ins_adr_o      (ins_adr_o),
        .ins_dat_o      (ins_dat_o)
    );

    always #20 CLK_IN = ~CLK_IN;                // 40 ns period

    // One Galois step with the old LSB as output bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Expected word at an address
    function automatic pm_dat_t expect_word(input pm_adr_t adr);
        return shadow[adr];
    endfunction

    // Strobed lanes take new data and others keep the old byte
    function automatic pm_dat_t merge_bytes(input pm_dat_t old, input pm_dat_t dat,
                                            input pm_strb_t strb);
        pm_dat_t res;
        res = old;
        for (int b = 0; b < `PM_STRB_W; b++)
        begin
            if (strb[b])
                res[b*8 +: 8] = dat[b*8 +: 8];
        end
        return res;
    endfunction

    // Draw n random bits with one LFSR step each
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    // Host load with optional pointer clear and random idle cycles
    task automatic init_load(input logic clr, input int n, input logic gaps);
        logic [31:0] r;
        @(negedge CLK_IN);
        if (clr)
        begin
            init_str_i = 1'b1;
            load_ptr   = '0;
            @(negedge CLK_IN);
            init_str_i = 1'b0;
        end
        for (int k = 0; k < n; k++)
        begin
            if (gaps)
            begin
                draw_bits(2, r);
                if (r[1:0] == 2'b00)                // One idle cycle in four
                begin
                    init_vld_i = 1'b0;
                    @(negedge CLK_IN);
                end
            end
            draw_bits(32, r);
            init_vld_i       = 1'b1;
            init_dat_i       = r;
            shadow[load_ptr] = r;                   // Full word at pointer
            load_ptr         = load_ptr + pm_adr_t'(1);
            @(negedge CLK_IN);
        end
        init_vld_i = 1'b0;
    endtask

    // Offer one patch and hold it until accepted
    task automatic patch_write(input pm_adr_t adr, input pm_dat_t dat, input pm_strb_t strb,
                               output int stalls);
        logic accepted;
        @(negedge CLK_IN);
        wr_vld_i  = 1'b1;
        wr_adr_i  = adr;
        wr_dat_i  = dat;
        wr_strb_i = strb;
        stalls    = 0;
        accepted  = 1'b0;
        while (!accepted)
        begin
            if (stalls == HS_LIMIT)
                fail_run("patch write was never accepted");
            else
            begin
                @(posedge CLK_IN);
                check_eq("wr_rdy_o", 32'(wr_rdy_o), 32'(!init_vld_i));
                if (wr_rdy_o)
                    accepted = 1'b1;
                else
                    stalls++;
            end
        end
        shadow[adr] = merge_bytes(shadow[adr], dat, strb);     // Only now visible
        @(negedge CLK_IN);
        wr_vld_i = 1'b0;
    endtask

    // Start at adr and take n words with ready held high or random
    task automatic run_fetch(input pm_adr_t adr, input int n, input logic rnd_rdy);
        int             cyc;
        logic [31:0]    r;
        @(negedge CLK_IN);
        start_i     = 1'b1;
        start_adr_i = adr;
        ins_rdy_i   = 1'b1;                         // Dropped in the start cycle
        @(negedge CLK_IN);
        start_i   = 1'b0;
        ins_rdy_i = 1'b0;
        cyc       = 0;
        while (ins_vld_o !== 1'b1)
        begin
            if (cyc == VLD_LIMIT)
                fail_run("ins_vld_o did not rise after start_i");
            else
            begin
                @(negedge CLK_IN);
                cyc++;
            end
        end
        cyc = 0;
        while (acc_cnt < n)
        begin
            if (cyc == n * 8 + 64)
                fail_run("instruction stream stopped before all words were taken");
            else
            begin
                if (rnd_rdy)
                begin
                    draw_bits(1, r);
                    ins_rdy_i = r[0];
                end
                else
                    ins_rdy_i = 1'b1;
                @(negedge CLK_IN);
                cyc++;
            end
        end
        ins_rdy_i = 1'b0;
    endtask

    // Compare every accepted word against the reference
    always @(posedge CLK_IN)
    begin
        pm_adr_t exp_adr;
        if (rst_i)
            started = 1'b0;
        else if (start_i)                           // Start beats the handshake
        begin
            started  = 1'b1;
            base_adr = start_adr_i;
            acc_cnt  = 0;
        end
        else if (ins_vld_o === 1'b1)
        begin
            if (!started)
                fail_run("ins_vld_o rose before the first start_i");
            else if (ins_rdy_i)
            begin
                exp_adr = pm_adr_t'(base_adr + acc_cnt);   // Wraps at end of memory
                check_eq("ins_adr_o", 32'(ins_adr_o), 32'(exp_adr));
                check_eq("ins_dat_o", ins_dat_o, expect_word(exp_adr));
                acc_cnt++;
            end
        end
    end

    initial
    begin
        pm_adr_t        a;
        pm_dat_t        d;
        pm_strb_t       s;
        logic [31:0]    r;
        int             stalls;

        CLK_IN      = 1'b0;
        rst_i       = 1'b1;
        init_str_i  = 1'b0;
        init_vld_i  = 1'b0;
        init_dat_i  = '0;
        wr_vld_i    = 1'b0;
        wr_adr_i    = '0;
        wr_dat_i    = '0;
        wr_strb_i   = '0;
        start_i     = 1'b0;
        start_adr_i = '0;
        ins_rdy_i   = 1'b0;
        load_ptr    = '0;
        lfsr_state  = LFSR_SEED;
        for (int k = 0; k < MEM_WORDS; k++)
            shadow[k] = '0;

        repeat (2) @(posedge CLK_IN);               // Two reset cycles
        @(negedge CLK_IN);
        rst_i = 1'b0;

        // Fetch idle until the first start
        repeat (5)
        begin
            @(negedge CLK_IN);
            check_eq("ins_vld_o", 32'(ins_vld_o), 32'd0);
        end

        // Full image with gaps then straight fetch
        init_load(1'b1, MEM_WORDS, 1'b1);
        run_fetch('0, MEM_WORDS, 1'b0);

        // Random patches in one window
        for (int k = 0; k < 12; k++)
        begin
            draw_bits(4, r);
            a = pm_adr_t'(32'h40 + r[3:0]);
            draw_bits(32, r);
            d = r;
            draw_bits(4, r);
            s = pm_strb_t'(r);
            patch_write(a, d, s, stalls);
        end
        run_fetch(pm_adr_t'(8'h40), 16, 1'b0);

        // Patch offered while init words stream
        draw_bits(4, r);
        a = pm_adr_t'(r[3:0]);                      // Inside the burst range
        draw_bits(32, r);
        d = r;
        draw_bits(4, r);
        s = pm_strb_t'(r);
        fork
            init_load(1'b0, 24, 1'b0);
            begin
                repeat (3) @(negedge CLK_IN);
                patch_write(a, d, s, stalls);
            end
        join
        if (stalls == 0)
            fail_run("patch write was accepted while init words streamed");
        run_fetch('0, 32, 1'b0);

        // Long back-pressured run across the wrap
        run_fetch(pm_adr_t'(8'd250), 300, 1'b1);

        // Restart with a full queue pending
        run_fetch(pm_adr_t'(8'd100), 10, 1'b1);
        repeat (6) @(negedge CLK_IN);               // Queue fills while nothing is taken
        run_fetch(pm_adr_t'(8'd200), 20, 1'b1);

        repeat (4) @(negedge CLK_IN);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
pm_pkg.sv
pm_sdp_ram.sv
pm_dp_ram.sv
pm_fetch.sv
pm_top.sv
tb_pm_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the program memory testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_pm_top -f tb.f -Mdir obj_dir \
    && ./obj_dir/Vtb_pm_top > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Result: PASSED" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
